//--- include/udp_echo_cfg.svh
`ifndef UDP_ECHO_CFG_SVH
`define UDP_ECHO_CFG_SVH

// NoC flit width in bits
`define NOC_DATA_WIDTH 256

// Mesh coordinates and endpoint function bits
`define XY_WIDTH 4
`define FBITS_WIDTH 4

// Packet interface endpoint on every tile
`define PKT_IF_FBITS 4'd2

// Header message length, counted in flits
`define MSG_LENGTH_WIDTH 8

// UDP payload length in bytes
`define UDP_LENGTH_W 16

// Payload bytes carried by one flit
`define FLIT_BYTES 32

`endif

//--- verilog/udp_echo_pkg.sv
`default_nettype none

`include "udp_echo_cfg.svh"

package udp_echo_pkg;

    // Message types seen by the echo tile
    typedef enum logic [7:0] {
        UDP_RX_SEGMENT = 8'h08,
        UDP_TX_SEGMENT = 8'h09
    } noc_msg_type_e;

    // Bits used by the named header fields
    localparam int HDR_USED_W = 4 * `XY_WIDTH
                              + 2 * `FBITS_WIDTH
                              + `MSG_LENGTH_WIDTH
                              + 8
                              + 16
                              + 64
                              + 8;
    localparam int HDR_PAD_W = `NOC_DATA_WIDTH - HDR_USED_W;

    // Header flit, destination first
    typedef struct packed {
        logic [`XY_WIDTH-1:0]         dst_x;
        logic [`XY_WIDTH-1:0]         dst_y;
        logic [`FBITS_WIDTH-1:0]      dst_fbits;
        logic [`MSG_LENGTH_WIDTH-1:0] msg_len;
        logic [`XY_WIDTH-1:0]         src_x;
        logic [`XY_WIDTH-1:0]         src_y;
        logic [`FBITS_WIDTH-1:0]      src_fbits;
        noc_msg_type_e                msg_type;
        logic [15:0]                  packet_id;
        logic [63:0]                  timestamp;
        logic [7:0]                   metadata_flits;
        logic [HDR_PAD_W-1:0]         padding;
    } noc_hdr_flit_t;

    // Addresses, ports and length
    localparam int META_USED_W = 32 + 32 + 16 + 16 + `UDP_LENGTH_W;
    localparam int META_PAD_W = `NOC_DATA_WIDTH - META_USED_W;

    typedef struct packed {
        logic [31:0]              src_ip;
        logic [31:0]              dst_ip;
        logic [15:0]              src_port;
        logic [15:0]              dst_port;
        logic [`UDP_LENGTH_W-1:0] data_length;
        logic [META_PAD_W-1:0]    padding;
    } udp_rx_meta_flit_t;

    // Same layout on the transmit side
    typedef struct packed {
        logic [31:0]              src_ip;
        logic [31:0]              dst_ip;
        logic [15:0]              src_port;
        logic [15:0]              dst_port;
        logic [`UDP_LENGTH_W-1:0] data_length;
        logic [META_PAD_W-1:0]    padding;
    } udp_tx_meta_flit_t;

    // Output data source
    typedef enum logic [1:0] {
        HDR_FLIT  = 2'd0,
        META_FLIT = 2'd1,
        DATA_FLIT = 2'd2
    } out_mux_sel_e;

    typedef enum logic [2:0] {
        RX_HDR  = 3'd0,
        RX_META = 3'd1,
        TX_HDR  = 3'd2,
        TX_META = 3'd3,
        TX_DATA = 3'd4
    } echo_state_e;

endpackage

`default_nettype wire

//--- verilog/udp_echo_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "udp_echo_cfg.svh"

interface udp_echo_ctrl_if;

    // Register strobes for the two stored flits
    logic                        store_hdr;
    logic                        store_meta;
    udp_echo_pkg::out_mux_sel_e  mux_sel;
    // Payload length of the stored metadata
    logic [`UDP_LENGTH_W-1:0]    data_length;

    modport ctrl (
        output store_hdr,
        output store_meta,
        output mux_sel,
        input  data_length
    );

    modport datap (
        input  store_hdr,
        input  store_meta,
        input  mux_sel,
        output data_length
    );

endinterface

`default_nettype wire

//--- verilog/udp_echo_app_datap.sv
`timescale 1ns/1ps
`default_nettype none

`include "udp_echo_cfg.svh"

module udp_echo_app_datap #(
     parameter int SRC_X = 0
    ,parameter int SRC_Y = 0
)(
     input  logic                       clk
    ,input  logic                       rst

    ,input  logic [`NOC_DATA_WIDTH-1:0] in_data
    ,output logic [`NOC_DATA_WIDTH-1:0] out_data

    ,input  logic [`XY_WIDTH-1:0]       dst_x
    ,input  logic [`XY_WIDTH-1:0]       dst_y

    ,udp_echo_ctrl_if.datap             ctrl
);

    udp_echo_pkg::noc_hdr_flit_t     hdr_reg;
    udp_echo_pkg::udp_rx_meta_flit_t meta_reg;

    udp_echo_pkg::noc_hdr_flit_t     out_hdr;
    udp_echo_pkg::udp_tx_meta_flit_t out_meta;

    assign ctrl.data_length = meta_reg.data_length;

    // Received flits, loaded on the accepting edge
    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_reg  <= '0;
            meta_reg <= '0;
        end
        else begin
            if (ctrl.store_hdr) begin
                hdr_reg <= in_data;
            end
            if (ctrl.store_meta) begin
                meta_reg <= in_data;
            end
        end
    end

    // Reply header toward the transmit engine
    always_comb begin
        out_hdr = '0;

        out_hdr.dst_x     = dst_x;
        out_hdr.dst_y     = dst_y;
        out_hdr.dst_fbits = `PKT_IF_FBITS;

        // Same flit count as the request
        out_hdr.msg_len   = hdr_reg.msg_len;
        out_hdr.src_x     = `XY_WIDTH'(SRC_X);
        out_hdr.src_y     = `XY_WIDTH'(SRC_Y);
        out_hdr.src_fbits = `PKT_IF_FBITS;

        out_hdr.msg_type       = udp_echo_pkg::UDP_TX_SEGMENT;
        out_hdr.packet_id      = hdr_reg.packet_id;
        out_hdr.timestamp      = hdr_reg.timestamp;
        out_hdr.metadata_flits = 8'd1;
    end

    // Swap endpoints so the reply goes back to the sender
    always_comb begin
        out_meta = '0;
        out_meta.src_ip      = meta_reg.dst_ip;
        out_meta.dst_ip      = meta_reg.src_ip;
        out_meta.src_port    = meta_reg.dst_port;
        out_meta.dst_port    = meta_reg.src_port;
        out_meta.data_length = meta_reg.data_length;
    end

    always_comb begin
        case (ctrl.mux_sel)
            udp_echo_pkg::HDR_FLIT: begin
                out_data = out_hdr;
            end
            udp_echo_pkg::META_FLIT: begin
                out_data = out_meta;
            end
            default: begin
                // Payload passes straight through
                out_data = in_data;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/udp_echo_app_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "udp_echo_cfg.svh"

module udp_echo_app_ctrl (
     input  logic            clk
    ,input  logic            rst

    ,input  logic            in_valid
    ,output logic            in_ready

    ,output logic            out_valid
    ,input  logic            out_ready

    ,udp_echo_ctrl_if.ctrl   ctrl
);

    localparam int BYTE_SHIFT = $clog2(`FLIT_BYTES);
    localparam int CNT_W = `UDP_LENGTH_W - BYTE_SHIFT + 1;
    localparam logic [`UDP_LENGTH_W:0] ROUND_UP = (`UDP_LENGTH_W + 1)'(`FLIT_BYTES - 1);

    udp_echo_pkg::echo_state_e state_reg;
    udp_echo_pkg::echo_state_e state_next;

    logic [CNT_W-1:0]         flit_cnt_reg;
    logic [CNT_W-1:0]         flit_cnt_next;
    logic [CNT_W-1:0]         num_flits;
    logic [`UDP_LENGTH_W:0]   len_round;

    logic in_xfer;
    logic out_xfer;

    assign in_xfer  = in_valid & in_ready;
    assign out_xfer = out_valid & out_ready;

    // Payload flits, length rounded up to whole flits
    assign len_round = {1'b0, ctrl.data_length} + ROUND_UP;
    assign num_flits = len_round[`UDP_LENGTH_W:BYTE_SHIFT];

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg    <= udp_echo_pkg::RX_HDR;
            flit_cnt_reg <= '0;
        end
        else begin
            state_reg    <= state_next;
            flit_cnt_reg <= flit_cnt_next;
        end
    end

    always_comb begin
        state_next      = state_reg;
        flit_cnt_next   = flit_cnt_reg;
        in_ready        = 1'b0;
        out_valid       = 1'b0;
        ctrl.store_hdr  = 1'b0;
        ctrl.store_meta = 1'b0;
        ctrl.mux_sel    = udp_echo_pkg::HDR_FLIT;

        case (state_reg)
            udp_echo_pkg::RX_HDR: begin
                in_ready       = 1'b1;
                ctrl.store_hdr = in_valid;
                if (in_xfer) begin
                    state_next = udp_echo_pkg::RX_META;
                end
            end
            udp_echo_pkg::RX_META: begin
                in_ready        = 1'b1;
                ctrl.store_meta = in_valid;
                if (in_xfer) begin
                    state_next = udp_echo_pkg::TX_HDR;
                end
            end
            udp_echo_pkg::TX_HDR: begin
                out_valid    = 1'b1;
                ctrl.mux_sel = udp_echo_pkg::HDR_FLIT;
                if (out_xfer) begin
                    state_next = udp_echo_pkg::TX_META;
                end
            end
            udp_echo_pkg::TX_META: begin
                out_valid    = 1'b1;
                ctrl.mux_sel = udp_echo_pkg::META_FLIT;
                if (out_xfer) begin
                    flit_cnt_next = num_flits;
                    // Empty payload ends the packet here
                    state_next = (num_flits != '0) ? udp_echo_pkg::TX_DATA
                                                   : udp_echo_pkg::RX_HDR;
                end
            end
            udp_echo_pkg::TX_DATA: begin
                // Input and output joined for the payload
                out_valid    = in_valid;
                in_ready     = out_ready;
                ctrl.mux_sel = udp_echo_pkg::DATA_FLIT;
                if (out_xfer) begin
                    flit_cnt_next = flit_cnt_reg - 1'b1;
                    if (flit_cnt_reg == CNT_W'(1)) begin
                        state_next = udp_echo_pkg::RX_HDR;
                    end
                end
            end
            default: begin
                state_next = udp_echo_pkg::RX_HDR;
            end
        endcase
    end

    // Stalled output holds its place
    a_stall_holds_state: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> $stable(state_reg));

    a_store_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(ctrl.store_hdr && ctrl.store_meta));

    // Payload state always has flits left
    a_cnt_no_underflow: assert property (@(posedge clk) disable iff (rst)
        (state_reg == udp_echo_pkg::TX_DATA) |-> (flit_cnt_reg != '0));

endmodule

`default_nettype wire

//--- verilog/udp_echo_app.sv
`timescale 1ns/1ps
`default_nettype none

`include "udp_echo_cfg.svh"

module udp_echo_app #(
     parameter int SRC_X = 0
    ,parameter int SRC_Y = 0
)(
     input  logic                       clk
    ,input  logic                       rst

    // Request stream from the NoC
    ,input  logic [`NOC_DATA_WIDTH-1:0] in_data
    ,input  logic                       in_valid
    ,output logic                       in_ready

    // Reply stream toward the transmit engine
    ,output logic [`NOC_DATA_WIDTH-1:0] out_data
    ,output logic                       out_valid
    ,input  logic                       out_ready

    ,input  logic [`XY_WIDTH-1:0]       dst_x
    ,input  logic [`XY_WIDTH-1:0]       dst_y
);

    udp_echo_ctrl_if ctrl_bus ();

    udp_echo_app_ctrl u_ctrl (
         .clk       (clk)
        ,.rst       (rst)
        ,.in_valid  (in_valid)
        ,.in_ready  (in_ready)
        ,.out_valid (out_valid)
        ,.out_ready (out_ready)
        ,.ctrl      (ctrl_bus.ctrl)
    );

    udp_echo_app_datap #(
         .SRC_X (SRC_X)
        ,.SRC_Y (SRC_Y)
    ) u_datap (
         .clk      (clk)
        ,.rst      (rst)
        ,.in_data  (in_data)
        ,.out_data (out_data)
        ,.dst_x    (dst_x)
        ,.dst_y    (dst_y)
        ,.ctrl     (ctrl_bus.datap)
    );

endmodule

`default_nettype wire

//--- dv/udp_echo_app_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "udp_echo_cfg.svh"

module udp_echo_app_tb;

    localparam int W     = `NOC_DATA_WIDTH;
    localparam int SRC_X = 2;
    localparam int SRC_Y = 3;

    // Packets over all tests, worst flits per packet, slack for stalls and gaps
    localparam int NUM_PKTS       = 16;
    localparam int MAX_PKT_FLITS  = 2 + (100 + `FLIT_BYTES - 1) / `FLIT_BYTES;
    localparam int STALL_FACTOR   = 8;
    localparam int TIMEOUT_CYCLES = NUM_PKTS * MAX_PKT_FLITS * STALL_FACTOR + 100;

    logic                 clk;
    logic                 rst;
    logic [W-1:0]         in_data;
    logic                 in_valid;
    logic                 in_ready;
    logic [W-1:0]         out_data;
    logic                 out_valid;
    logic                 out_ready = 1'b1;
    logic [`XY_WIDTH-1:0] dst_x;
    logic [`XY_WIDTH-1:0] dst_y;

    // Reply flits in the order the DUT must send them
    logic [W-1:0] exp_q[$];
    logic [W-1:0] exp_flit;
    logic [W-1:0] held_data;
    logic         stalled;
    logic         stall_en;
    int           errors = 0;
    int           checks = 0;
    int           cycle_cnt = 0;

    udp_echo_app #(
         .SRC_X (SRC_X)
        ,.SRC_Y (SRC_Y)
    ) uut (
         .clk       (clk)
        ,.rst       (rst)
        ,.in_data   (in_data)
        ,.in_valid  (in_valid)
        ,.in_ready  (in_ready)
        ,.out_data  (out_data)
        ,.out_valid (out_valid)
        ,.out_ready (out_ready)
        ,.dst_x     (dst_x)
        ,.dst_y     (dst_y)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, DUT stopped moving flits", cycle_cnt);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // Transmit engine side, random stalls when enabled
    always @(posedge clk) begin
        #1;
        out_ready = stall_en ? (($urandom % 3) != 0) : 1'b1;
    end

    always @(posedge clk) begin
        if (rst) begin
            stalled <= 1'b0;
        end
        else begin
            if (stalled) begin
                checks = checks + 1;
                assert (out_valid && out_data == held_data) else begin
                    errors = errors + 1;
                    $display("FAIL %0t: output flit changed or dropped while stalled", $time);
                end
            end
            if (out_valid && out_ready) begin
                checks = checks + 1;
                assert (exp_q.size() != 0) else begin
                    errors = errors + 1;
                    $display("Output flit at %0t arrived with no reply expected", $time);
                end
                if (exp_q.size() != 0) begin
                    exp_flit = exp_q.pop_front();
                    assert (out_data == exp_flit) else begin
                        errors = errors + 1;
                        $display("FAIL %0t: out_data %h, expected %h", $time, out_data, exp_flit);
                    end
                end
            end
            stalled   <= out_valid && !out_ready;
            held_data <= out_data;
        end
    end

    function automatic logic [W-1:0] random_flit();
        logic [W-1:0] flit;
        int           i;
        for (i = 0; i < W / 32; i++) begin
            flit[i*32 +: 32] = $urandom;
        end
        return flit;
    endfunction

    // One flit under valid/ready, optional idle gap first
    task automatic send_flit(input logic [W-1:0] flit, input bit gaps);
        int gap;
        gap = 0;
        if (gaps && ($urandom % 3) == 0) begin
            gap = 1 + $urandom % 3;
        end
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        in_data  = flit;
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic send_packet(input int len, input bit gaps);
        udp_echo_pkg::noc_hdr_flit_t     rx_hdr;
        udp_echo_pkg::noc_hdr_flit_t     tx_hdr;
        udp_echo_pkg::udp_rx_meta_flit_t rx_meta;
        udp_echo_pkg::udp_tx_meta_flit_t tx_meta;
        logic [W-1:0]                    payload[$];
        int                              nflits;
        int                              i;

        nflits = (len + `FLIT_BYTES - 1) / `FLIT_BYTES;
        for (i = 0; i < nflits; i++) begin
            payload.push_back(random_flit());
        end

        // Padding left random, the reply has to clear it
        rx_hdr                = random_flit();
        rx_hdr.dst_x          = `XY_WIDTH'(SRC_X);
        rx_hdr.dst_y          = `XY_WIDTH'(SRC_Y);
        rx_hdr.dst_fbits      = `PKT_IF_FBITS;
        rx_hdr.msg_len        = `MSG_LENGTH_WIDTH'(nflits + 1);
        rx_hdr.src_x          = `XY_WIDTH'($urandom);
        rx_hdr.src_y          = `XY_WIDTH'($urandom);
        rx_hdr.src_fbits      = `FBITS_WIDTH'($urandom);
        rx_hdr.msg_type       = udp_echo_pkg::UDP_RX_SEGMENT;
        rx_hdr.packet_id      = 16'($urandom);
        rx_hdr.timestamp      = {$urandom, $urandom};
        rx_hdr.metadata_flits = 8'd1;

        rx_meta             = random_flit();
        rx_meta.src_ip      = $urandom;
        rx_meta.dst_ip      = $urandom;
        rx_meta.src_port    = 16'($urandom);
        rx_meta.dst_port    = 16'($urandom);
        rx_meta.data_length = `UDP_LENGTH_W'(len);

        // Reply goes from this tile to the transmit engine
        tx_hdr                = '0;
        tx_hdr.dst_x          = dst_x;
        tx_hdr.dst_y          = dst_y;
        tx_hdr.dst_fbits      = `PKT_IF_FBITS;
        tx_hdr.msg_len        = rx_hdr.msg_len;
        tx_hdr.src_x          = `XY_WIDTH'(SRC_X);
        tx_hdr.src_y          = `XY_WIDTH'(SRC_Y);
        tx_hdr.src_fbits      = `PKT_IF_FBITS;
        tx_hdr.msg_type       = udp_echo_pkg::UDP_TX_SEGMENT;
        tx_hdr.packet_id      = rx_hdr.packet_id;
        tx_hdr.timestamp      = rx_hdr.timestamp;
        tx_hdr.metadata_flits = 8'd1;

        tx_meta             = '0;
        tx_meta.src_ip      = rx_meta.dst_ip;
        tx_meta.dst_ip      = rx_meta.src_ip;
        tx_meta.src_port    = rx_meta.dst_port;
        tx_meta.dst_port    = rx_meta.src_port;
        tx_meta.data_length = rx_meta.data_length;

        exp_q.push_back(tx_hdr);
        exp_q.push_back(tx_meta);
        for (i = 0; i < nflits; i++) begin
            exp_q.push_back(payload[i]);
        end

        send_flit(rx_hdr, gaps);
        send_flit(rx_meta, gaps);
        for (i = 0; i < nflits; i++) begin
            send_flit(payload[i], gaps);
        end
    endtask

    task automatic drain_replies();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic reset_state_check();
        @(negedge clk);
        checks = checks + 1;
        assert (!out_valid && in_ready) else begin
            errors = errors + 1;
            $display("FAIL %0t: after reset out_valid=%b in_ready=%b, expected 0 and 1",
                     $time, out_valid, in_ready);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic header_rewrite();
        dst_x = 4'd5;
        dst_y = 4'd1;
        send_packet(16, 1'b0);
        drain_replies();
    endtask

    // Empty payload ends after two reply flits
    task automatic meta_swap();
        send_packet(0, 1'b0);
        drain_replies();
        @(negedge clk);
        checks = checks + 1;
        assert (in_ready) else begin
            errors = errors + 1;
            $display("FAIL %0t: in_ready low after an empty packet, next header blocked",
                     $time);
        end
        @(posedge clk);
        #1;
        send_packet(0, 1'b0);
        send_packet(40, 1'b0);
        drain_replies();
    endtask

    task automatic payload_lengths();
        int lens[4] = '{1, 32, 33, 100};
        int i;
        for (i = 0; i < 4; i++) begin
            send_packet(lens[i], 1'b0);
        end
        drain_replies();
    endtask

    task automatic backpressure_mix();
        int i;
        dst_x    = 4'd9;
        dst_y    = 4'd6;
        stall_en = 1'b1;
        for (i = 0; i < 8; i++) begin
            send_packet($urandom % 101, 1'b1);
        end
        drain_replies();
        stall_en = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h2d1a));
        rst      = 1'b1;
        in_data  = '0;
        in_valid = 1'b0;
        dst_x    = '0;
        dst_y    = '0;
        stall_en = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        reset_state_check();
        header_rewrite();
        meta_swap();
        payload_lengths();
        backpressure_mix();

        // Back to waiting for a header once the last reply is out
        checks = checks + 1;
        assert (!out_valid && in_ready) else begin
            errors = errors + 1;
            $display("FAIL %0t: DUT not idle after the last reply, out_valid=%b in_ready=%b",
                     $time, out_valid, in_ready);
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end
        else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
verilog/udp_echo_pkg.sv
verilog/udp_echo_ctrl_if.sv
verilog/udp_echo_app_datap.sv
verilog/udp_echo_app_ctrl.sv
verilog/udp_echo_app.sv
dv/udp_echo_app_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = udp_echo_app_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_MSG  = RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
